//--- source/ks_pkg.sv
`default_nettype none

package ks_pkg;

    parameter int DATA_W = 64;  // operand width

    typedef logic [DATA_W-1:0] word_t;  // operands, sums, propagate/generate
    typedef logic [31:0]       count_t; // counters and APB data
    typedef logic [7:0]        apb_addr_t;

    // one pipeline slot between the pg, prefix and sum stages
    typedef struct packed {
        logic  valid;
        logic  sub;    // subtract op, b already inverted
        logic  msb_a;  // sign of a
        logic  msb_b;  // sign of b after inversion
        word_t p;      // bitwise propagate, kept for the sum
        word_t gp;     // group propagate
        word_t gg;     // group generate, carry out of bit i when done
        logic  cin;    // carry into bit 0
    } pg_word_t;

    // finished result
    typedef struct packed {
        logic  valid;
        word_t sum;
        logic  cout;
        logic  ovf;
    } result_t;

    // APB register map
    localparam apb_addr_t REG_OPS   = 8'h00;
    localparam apb_addr_t REG_COUT  = 8'h04;
    localparam apb_addr_t REG_OVF   = 8'h08;
    localparam apb_addr_t REG_CLEAR = 8'h0C;

endpackage

`default_nettype wire

//--- source/ks_pg_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ks_pg_stage
    import ks_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  word_t    in_a,
    input  word_t    in_b,
    input  logic     in_cin,
    input  logic     in_sub,
    output pg_word_t pg_out
);

    word_t    b_eff;
    logic     cin_eff;
    word_t    p;
    word_t    g;
    pg_word_t pg_next;

    // a - b = a + ~b + 1, the caller's cin is dropped
    assign b_eff   = in_sub ? ~in_b : in_b;
    assign cin_eff = in_sub ? 1'b1 : in_cin;

    assign p = in_a ^ b_eff;
    assign g = in_a & b_eff;

    always_comb begin
        pg_next.valid = in_valid;
        pg_next.sub   = in_sub;
        pg_next.msb_a = in_a[DATA_W-1];
        pg_next.msb_b = b_eff[DATA_W-1];
        pg_next.p     = p;
        pg_next.cin   = cin_eff;
        // bit 0 absorbs the carry-in here, so its group already reaches
        // down to position -1 and needs no further combining
        pg_next.gg    = {g[DATA_W-1:1], g[0] | (p[0] & cin_eff)};
        pg_next.gp    = {p[DATA_W-1:1], 1'b0};
    end

    always_ff @(posedge clk) begin
        pg_out <= pg_next;
        if (rst) begin
            pg_out.valid <= 1'b0;  // payload keeps its value
        end
    end

    // no X may enter the carry tree on an accepted op
    a_known_operands: assert property (
        @(posedge clk) disable iff (rst)
        in_valid |-> !$isunknown({in_a, in_b, in_cin, in_sub})
    ) else $error("ks_pg_stage: unknown operand while in_valid is high");

endmodule

`default_nettype wire

//--- source/ks_prefix_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ks_prefix_stage
    import ks_pkg::*;
#(
    parameter int FIRST_DIST = 1,  // distance of the first level in this stage
    parameter int NUM_LEVELS = 2
) (
    input  logic     clk,
    input  logic     rst,
    input  pg_word_t pg_in,
    output pg_word_t pg_out
);

    // level 0 is the stage input, level NUM_LEVELS the combined result
    word_t    gp_lvl [NUM_LEVELS+1];
    word_t    gg_lvl [NUM_LEVELS+1];
    pg_word_t pg_next;

    assign gp_lvl[0] = pg_in.gp;
    assign gg_lvl[0] = pg_in.gg;

    genvar lvl;
    genvar i;
    generate
        for (lvl = 0; lvl < NUM_LEVELS; lvl++) begin : g_level
            localparam int DIST = FIRST_DIST << lvl;

            for (i = 0; i < DATA_W; i++) begin : g_bit
                if (i >= DIST) begin : g_comb
                    // (g, p)[i] o (g, p)[i-DIST]
                    assign gg_lvl[lvl+1][i] = gg_lvl[lvl][i] |
                                              (gp_lvl[lvl][i] & gg_lvl[lvl][i-DIST]);
                    assign gp_lvl[lvl+1][i] = gp_lvl[lvl][i] & gp_lvl[lvl][i-DIST];
                end else begin : g_pass
                    // group already spans bit 0 and with it the carry-in
                    assign gg_lvl[lvl+1][i] = gg_lvl[lvl][i];
                    assign gp_lvl[lvl+1][i] = gp_lvl[lvl][i];
                end
            end
        end
    endgenerate

    always_comb begin
        pg_next    = pg_in;  // sign bits, p and cin ride along
        pg_next.gp = gp_lvl[NUM_LEVELS];
        pg_next.gg = gg_lvl[NUM_LEVELS];
    end

    always_ff @(posedge clk) begin
        pg_out <= pg_next;
        if (rst) begin
            pg_out.valid <= 1'b0;
        end
    end

    // positions below the first distance arrive as finished groups
    a_low_groups_done: assert property (
        @(posedge clk) disable iff (rst)
        pg_in.valid |-> (pg_in.gp[FIRST_DIST-1:0] == '0)
    ) else $error("ks_prefix_stage: unfinished group below the first distance");

endmodule

`default_nettype wire

//--- source/ks_sum_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ks_sum_stage
    import ks_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  pg_word_t pg_in,
    output result_t  res
);

    word_t   carries;  // carry into each bit
    word_t   sum;
    logic    cout;
    logic    ovf;
    result_t res_next;

    // carry into bit i is the group generate of bit i-1, bit 0 takes cin
    assign carries = {pg_in.gg[DATA_W-2:0], pg_in.cin};

    assign sum  = pg_in.p ^ carries;
    assign cout = pg_in.gg[DATA_W-1];  // for subtract, 1 means no borrow

    // same-signed operands giving a result of the other sign
    assign ovf = (pg_in.msb_a == pg_in.msb_b) && (sum[DATA_W-1] != pg_in.msb_a);

    always_comb begin
        res_next.valid = pg_in.valid;
        res_next.sum   = sum;
        res_next.cout  = cout;
        res_next.ovf   = ovf;
    end

    always_ff @(posedge clk) begin
        res <= res_next;
        if (rst) begin
            res.valid <= 1'b0;
        end
    end

    // the pg stage must have forced the +1 of two's complement
    a_sub_cin: assert property (
        @(posedge clk) disable iff (rst)
        (pg_in.valid && pg_in.sub) |-> pg_in.cin
    ) else $error("ks_sum_stage: subtract reached the sum without carry-in");

endmodule

`default_nettype wire

//--- source/ks_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ks_apb_regs
    import ks_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  count_t    pwdata,
    output count_t    prdata,
    output logic      pready,
    output logic      pslverr,
    input  result_t   res
);

    count_t ops_cnt;
    count_t cout_cnt;
    count_t ovf_cnt;

    logic access;    // APB access phase
    logic addr_hit;
    logic ro_write;  // write to one of the counters
    logic clear;

    assign access = psel && penable;

    always_comb begin
        case (paddr)
            REG_OPS, REG_COUT, REG_OVF, REG_CLEAR: addr_hit = 1'b1;
            default:                               addr_hit = 1'b0;
        endcase
    end

    assign ro_write = pwrite && addr_hit && (paddr != REG_CLEAR);
    assign clear    = access && pwrite && (paddr == REG_CLEAR);

    // clear beats a result on the same edge
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            ops_cnt  <= '0;
            cout_cnt <= '0;
            ovf_cnt  <= '0;
        end else if (res.valid) begin
            ops_cnt  <= ops_cnt + 1'b1;              // wraps at 2^32
            cout_cnt <= cout_cnt + count_t'(res.cout);
            ovf_cnt  <= ovf_cnt + count_t'(res.ovf);
        end
    end

    // read mux straight off the counter flops
    always_comb begin
        case (paddr)
            REG_OPS:  prdata = ops_cnt;
            REG_COUT: prdata = cout_cnt;
            REG_OVF:  prdata = ovf_cnt;
            default:  prdata = '0;  // REG_CLEAR and holes
        endcase
    end

    assign pready  = 1'b1;  // zero wait states
    assign pslverr = access && (!addr_hit || ro_write);

    // access phase only ever follows a selected setup phase
    a_penable_psel: assert property (
        @(posedge clk) disable iff (rst)
        penable |-> psel
    ) else $error("ks_apb_regs: penable without psel");

    // the clear register takes any value, but the bus must still drive one
    a_wdata_known: assert property (
        @(posedge clk) disable iff (rst)
        (access && pwrite) |-> !$isunknown(pwdata)
    ) else $error("ks_apb_regs: unknown pwdata on write");

endmodule

`default_nettype wire

//--- source/ks_adder_top.sv
`timescale 1ns/1ps
`default_nettype none

module ks_adder_top
    import ks_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // operand stream
    input  logic      in_valid,
    input  word_t     in_a,
    input  word_t     in_b,
    input  logic      in_cin,
    input  logic      in_sub,
    // result stream, 5 cycles behind the input
    output logic      out_valid,
    output word_t     out_sum,
    output logic      out_cout,
    output logic      out_ovf,
    // APB3 status registers
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  count_t    pwdata,
    output count_t    prdata,
    output logic      pready,
    output logic      pslverr
);

    pg_word_t pg_0;  // after pg stage
    pg_word_t pg_1;  // distances 1, 2
    pg_word_t pg_2;  // distances 4, 8
    pg_word_t pg_3;  // distances 16, 32
    result_t  res;

    ks_pg_stage u_pg (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_a     (in_a),
        .in_b     (in_b),
        .in_cin   (in_cin),
        .in_sub   (in_sub),
        .pg_out   (pg_0)
    );

    ks_prefix_stage #(.FIRST_DIST(1), .NUM_LEVELS(2)) u_prefix_0 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_0),
        .pg_out (pg_1)
    );

    ks_prefix_stage #(.FIRST_DIST(4), .NUM_LEVELS(2)) u_prefix_1 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_1),
        .pg_out (pg_2)
    );

    ks_prefix_stage #(.FIRST_DIST(16), .NUM_LEVELS(2)) u_prefix_2 (
        .clk    (clk),
        .rst    (rst),
        .pg_in  (pg_2),
        .pg_out (pg_3)
    );

    ks_sum_stage u_sum (
        .clk   (clk),
        .rst   (rst),
        .pg_in (pg_3),
        .res   (res)
    );

    ks_apb_regs u_regs (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .res     (res)
    );

    assign out_valid = res.valid;
    assign out_sum   = res.sum;
    assign out_cout  = res.cout;
    assign out_ovf   = res.ovf;

endmodule

`default_nettype wire

//--- tb/tb_ks_adder.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ks_adder
    import ks_pkg::*;
();

    localparam int LATENCY  = 5;
    localparam int WAIT_MAX = 64;  // cycles before any wait gives up

    typedef struct packed {
        word_t  sum;
        logic   cout;
        logic   ovf;
        count_t due;  // cycle the result has to appear
    } expect_t;

    logic      clk;
    logic      rst;
    logic      in_valid;
    word_t     in_a;
    word_t     in_b;
    logic      in_cin;
    logic      in_sub;
    logic      out_valid;
    word_t     out_sum;
    logic      out_cout;
    logic      out_ovf;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    count_t    pwdata;
    count_t    prdata;
    logic      pready;
    logic      pslverr;

    expect_t exp_q[$];
    count_t  seed       = 32'hcb105b00;
    count_t  cycle      = '0;
    int      n_checks   = 0;
    int      n_errors   = 0;
    string   cur_test   = "reset";
    int      valid_run  = 0;
    int      best_run   = 0;
    count_t  tally_ops  = '0;  // what the APB counters should hold
    count_t  tally_cout = '0;
    count_t  tally_ovf  = '0;

    ks_adder_top i_dut (.*);

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1'b1;

    function automatic count_t lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t rand_word();
        count_t hi;
        count_t lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi, lo};
    endfunction

    // 65-bit reference model with subtraction as a + ~b + 1
    function automatic expect_t model(word_t a, word_t b, logic cin, logic sub);
        word_t           b_eff;
        logic [DATA_W:0] full;
        expect_t         e;
        b_eff  = sub ? ~b : b;
        full   = {1'b0, a} + {1'b0, b_eff} + (DATA_W+1)'(sub ? 1'b1 : cin);
        e.sum  = full[DATA_W-1:0];
        e.cout = full[DATA_W];
        e.ovf  = (a[DATA_W-1] == b_eff[DATA_W-1]) && (e.sum[DATA_W-1] != a[DATA_W-1]);
        e.due  = '0;
        return e;
    endfunction

    task automatic check_value(input string what, input word_t exp, input word_t act);
        n_checks++;
        assert (exp === act) else begin
            n_errors++;
            $display("FAILED %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("ERROR %s: timed out waiting for %s", cur_test, what);
        $display("checks: %0d, errors: %0d", n_checks, n_errors + 1);
        $display("Regression failed");
        $finish;
    endtask

    // scoreboard samples on the falling edge where outputs are stable
    always @(negedge clk) begin
        expect_t e;
        if (rst || !out_valid) begin
            valid_run = 0;
        end else begin
            valid_run++;
            if (valid_run > best_run) begin
                best_run = valid_run;
            end
            n_checks++;
            assert (exp_q.size() != 0) else begin
                n_errors++;
                $display("ERROR %s: out_valid high with no operation outstanding", cur_test);
            end
            if (exp_q.size() != 0) begin
                e = exp_q.pop_front();
                check_value("sum", e.sum, out_sum);
                check_value("cout", e.cout, out_cout);
                check_value("ovf", e.ovf, out_ovf);
                check_value("latency", e.due, cycle);
                tally_ops  += 1;
                tally_cout += e.cout;
                tally_ovf  += e.ovf;
            end
        end
    end

    // drives one op for a single cycle starting at a falling edge
    task automatic issue(input word_t a, input word_t b, input logic cin, input logic sub);
        expect_t e;
        e     = model(a, b, cin, sub);
        e.due = cycle + LATENCY;
        exp_q.push_back(e);
        in_valid = 1'b1;
        in_a     = a;
        in_b     = b;
        in_cin   = cin;
        in_sub   = sub;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int t;
        for (t = 0; t < WAIT_MAX && exp_q.size() != 0; t++) begin
            @(negedge clk);
        end
        if (exp_q.size() != 0) begin
            abort_on_timeout("outstanding results");
        end else begin
            repeat (3) @(negedge clk);  // idle tail catches stray valids
        end
    endtask

    task automatic apb_xfer(input logic write, input apb_addr_t addr, input count_t wdata,
                            output count_t rdata, output logic err);
        int t;
        psel    = 1'b1;  // setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        for (t = 0; t < WAIT_MAX && !pready; t++) begin
            @(negedge clk);
            #1;
        end
        if (!pready) begin
            abort_on_timeout("pready");
        end else begin
            check_value("pready wait states", '0, t);
            rdata = prdata;
            err   = pslverr;
            @(negedge clk);  // access completes on the edge before this
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic read_expect(input apb_addr_t addr, input count_t exp, input string what);
        count_t rd;
        logic   err;
        apb_xfer(1'b0, addr, '0, rd, err);
        check_value(what, exp, rd);
        check_value({what, " pslverr"}, 1'b0, err);
    endtask

    task automatic test_corner_add();
        cur_test = "test_corner_add";
        issue('0, '0, 1'b0, 1'b0);
        issue('1, 64'd1, 1'b0, 1'b0);                     // carry out of the top
        issue({32{2'b10}}, {32{2'b01}}, 1'b1, 1'b0);      // cin runs all 64 bits
        issue({32{2'b10}}, {32{2'b10}}, 1'b0, 1'b0);
        issue('1, '0, 1'b1, 1'b0);
        issue(64'h7fff_ffff_ffff_ffff, 64'd1, 1'b0, 1'b0);  // positive overflow
        wait_drained();
    endtask

    task automatic test_subtract();
        cur_test = "test_subtract";
        issue(64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, 1'b0, 1'b1);  // no borrow
        issue('0, 64'd1, 1'b0, 1'b1);                                        // borrow
        issue(64'h8000_0000_0000_0000, 64'd1, 1'b1, 1'b1);  // overflow with cin ignored
        wait_drained();
    endtask

    task automatic test_back_to_back();
        int     k;
        word_t  a;
        word_t  b;
        count_t r;
        cur_test = "test_back_to_back";
        best_run = 0;
        for (k = 0; k < 200; k++) begin
            a = rand_word();
            b = rand_word();
            r = lcg_next();
            issue(a, b, r[31], r[30]);  // high bits since low LCG bits repeat fast
        end
        wait_drained();
        check_value("out_valid run", 200, best_run);
    endtask

    task automatic test_gaps();
        int     k;
        word_t  a;
        word_t  b;
        count_t r;
        cur_test = "test_gaps";
        for (k = 0; k < 40; k++) begin
            a = rand_word();
            b = rand_word();
            r = lcg_next();
            issue(a, b, r[31], r[30]);
            repeat (int'(r[29:27])) @(negedge clk);
        end
        wait_drained();
    endtask

    task automatic test_apb_errors();
        count_t rd;
        logic   err;
        cur_test = "test_apb_errors";
        apb_xfer(1'b0, 8'h10, '0, rd, err);
        check_value("pslverr unmapped", 1'b1, err);
        apb_xfer(1'b1, REG_OPS, 32'hdead_beef, rd, err);
        check_value("pslverr counter write", 1'b1, err);
        read_expect(REG_OPS, tally_ops, "REG_OPS after write");
    endtask

    task automatic test_counters();
        count_t rd;
        logic   err;
        cur_test = "test_counters";
        read_expect(REG_OPS, tally_ops, "REG_OPS");
        read_expect(REG_COUT, tally_cout, "REG_COUT");
        read_expect(REG_OVF, tally_ovf, "REG_OVF");
        apb_xfer(1'b1, REG_CLEAR, 32'h1, rd, err);
        check_value("pslverr clear", 1'b0, err);
        read_expect(REG_OPS, '0, "REG_OPS cleared");
        read_expect(REG_COUT, '0, "REG_COUT cleared");
        read_expect(REG_OVF, '0, "REG_OVF cleared");
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_a     = '0;
        in_b     = '0;
        in_cin   = 1'b0;
        in_sub   = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_corner_add();
        test_subtract();
        test_back_to_back();
        test_gaps();
        test_apb_errors();  // runs before the clear so the counter is nonzero
        test_counters();

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ks_adder_top.f
source/ks_pkg.sv
source/ks_pg_stage.sv
source/ks_prefix_stage.sv
source/ks_sum_stage.sv
source/ks_apb_regs.sv
source/ks_adder_top.sv
tb/tb_ks_adder.sv

//--- Bender.yml
package:
  name: ks_adder

sources:
  - files:
      - source/ks_pkg.sv
      - source/ks_pg_stage.sv
      - source/ks_prefix_stage.sv
      - source/ks_sum_stage.sv
      - source/ks_apb_regs.sv
      - source/ks_adder_top.sv
  - target: simulation
    files:
      - tb/tb_ks_adder.sv
